/* eth_dump.f */
+incdir+include
logic/eth_dump_pkg.sv
logic/capture_fsm.sv
logic/rx_word_packer.sv
logic/frame_addr_counter.sv
logic/frame_ram.sv
logic/hex_dump_tx.sv
logic/eth_dump_top.sv
verification/eth_dump_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the eth_dump testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f eth_dump.f --top-module eth_dump_tb -o eth_dump_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/eth_dump_sim > sim.log 2>&1
cat sim.log
# any error in the testbench ends with the fail line in the log
test -f sim.log && ! grep -q "test failed" sim.log && exit 0 || exit 1

/* verification/eth_dump_tb.sv */
`include "eth_dump_defs.svh"

module eth_dump_tb
    import eth_dump_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 1000;
    // bytes that fit in the frame ram
    localparam int CAP_BYTES = `ETH_FRAME_DEPTH * 4;

    // one frame per row
    typedef struct packed {
        logic [15:0] n_bytes;
        logic        arm;
        logic        rand_ready;
        logic [15:0] exp_chars;
        logic        exp_ovf;
    } frame_row_t;

    logic        mainclk;
    logic        rst;
    logic        arm;
    mii_rx_t     mii_rx;
    logic        tx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        busy;
    logic        overflow;

    frame_row_t  rows [$];
    logic [7:0]  frame_bytes [$];
    logic [7:0]  exp_str [$];
    logic        ready_toggle;
    logic [31:0] data_seed;
    logic [31:0] ready_seed;
    logic        prev_valid;
    logic        prev_ready;
    int          n_chars;

    eth_dump_top u_dut (
        .mainclk  (mainclk),
        .rst      (rst),
        .arm      (arm),
        .mii_rx   (mii_rx),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .busy     (busy),
        .overflow (overflow)
    );

    initial begin
        mainclk = 1'b0;
        forever begin
            #10 mainclk = ~mainclk;
        end
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ascii digits start at 8'h30 and letters at 8'h61
    function automatic logic [7:0] ascii_hex(logic [3:0] n);
        if (n <= 4'd9) begin
            return 8'h30 + {4'h0, n};
        end
        return 8'h61 + {4'h0, n} - 8'd10;
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_problem(string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_char(int idx, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("char %0d is 0x%02h, expected 0x%02h", idx, got, exp));
        end
    endtask

    task automatic check_count(frame_len_t got, frame_len_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%0d words dumped, expected %0d", got, exp));
        end
    endtask

    task automatic check_overflow(logic got, logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("overflow is %b, expected %b", got, exp));
        end
    endtask

    // random frame bytes plus the hex string they should produce
    task automatic build_frame(int n);
        int kept;
        frame_bytes.delete();
        exp_str.delete();
        for (int i = 0; i < n; i++) begin
            data_seed = lcg_next(data_seed);
            frame_bytes.push_back(data_seed[23:16]);
        end
        // only whole words and no more than the ram holds
        kept = (n / 4) * 4;
        if (kept > CAP_BYTES) begin
            kept = CAP_BYTES;
        end
        for (int i = 0; i < kept; i++) begin
            exp_str.push_back(ascii_hex(frame_bytes[i][7:4]));
            exp_str.push_back(ascii_hex(frame_bytes[i][3:0]));
        end
    endtask

    // lead nibble then low and high nibble of each byte with dv held high
    task automatic send_frame(frame_row_t row);
        @(posedge mainclk);
        arm          <= row.arm;
        ready_toggle <= row.rand_ready;
        mii_rx       <= '{dv: 1'b1, data: 4'h5};
        for (int i = 0; i < frame_bytes.size(); i++) begin
            @(posedge mainclk);
            mii_rx <= '{dv: 1'b1, data: frame_bytes[i][3:0]};
            @(posedge mainclk);
            mii_rx <= '{dv: 1'b1, data: frame_bytes[i][7:4]};
        end
        @(posedge mainclk);
        mii_rx <= '{dv: 1'b0, data: 4'h0};
    endtask

    // one char per tx_valid cycle until the dump ends
    task automatic collect_chars(output int count);
        int   idle;
        logic done;
        count = 0;
        done  = 1'b0;
        while (!done) begin
            idle = 0;
            @(negedge mainclk);
            while (!tx_valid && busy && idle < TIMEOUT_CYCLES) begin
                @(negedge mainclk);
                idle++;
            end
            if (tx_valid) begin
                if (count >= exp_str.size()) begin
                    report_problem("the DUT sent more characters than the frame holds");
                end else begin
                    check_char(count, tx_data, exp_str[count]);
                end
                count++;
            end else if (!busy) begin
                done = 1'b1;
            end else begin
                report_problem("timeout waiting for tx_valid during the dump");
            end
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < TIMEOUT_CYCLES) begin
            @(negedge mainclk);
            cycles++;
        end
        if (busy) begin
            report_problem("timeout waiting for busy to return low");
        end
    endtask

    // tx_ready toggled by its own lcg when the row asks for it
    initial begin
        tx_ready   = 1'b1;
        ready_seed = 32'd61;
        forever begin
            @(posedge mainclk);
            if (ready_toggle) begin
                ready_seed = lcg_next(ready_seed);
                tx_ready <= ready_seed[20];
            end else begin
                tx_ready <= 1'b1;
            end
        end
    end

    // strobe rule and arm gating sampled on the edge
    always @(posedge mainclk) begin
        if (rst) begin
            prev_valid <= 1'b0;
            prev_ready <= 1'b0;
        end else begin
            if (tx_valid && prev_valid) begin
                report_mismatch("tx_valid high for two cycles in a row");
            end
            if (tx_valid && !prev_valid && !prev_ready) begin
                report_mismatch("tx_valid rose after a cycle with tx_ready low");
            end
            if (!arm && busy) begin
                report_mismatch("busy went high while arm was low");
            end
            prev_valid <= tx_valid;
            prev_ready <= tx_ready;
        end
    end

    initial begin
        rst          = 1'b1;
        arm          = 1'b0;
        mii_rx       = '0;
        ready_toggle = 1'b0;
        data_seed    = 32'd61;
        // bytes, arm, random ready, chars, overflow
        rows.push_back('{16'd64, 1'b1, 1'b0, 16'd128, 1'b0});
        rows.push_back('{16'd10, 1'b1, 1'b0, 16'd16, 1'b0});
        rows.push_back('{16'd3, 1'b1, 1'b0, 16'd0, 1'b0});
        rows.push_back('{16'd64, 1'b0, 1'b0, 16'd0, 1'b0});
        rows.push_back('{16'd64, 1'b1, 1'b1, 16'd128, 1'b0});
        rows.push_back('{16'd2100, 1'b1, 1'b0, 16'd4096, 1'b1});
        repeat (16) @(posedge mainclk);
        rst <= 1'b0;
        repeat (4) @(posedge mainclk);
        for (int r = 0; r < rows.size(); r++) begin
            build_frame(int'(rows[r].n_bytes));
            send_frame(rows[r]);
            collect_chars(n_chars);
            wait_idle();
            if (n_chars % 8 != 0) begin
                report_problem($sformatf("frame %0d ended inside a word", r));
            end
            check_count(frame_len_t'(n_chars / 8), frame_len_t'(rows[r].exp_chars / 8));
            check_overflow(overflow, rows[r].exp_ovf);
            repeat (4) @(posedge mainclk);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* logic/eth_dump_top.sv */
module eth_dump_top
    import eth_dump_pkg::*;
(
    input  logic       mainclk,
    input  logic       rst,
    input  logic       arm,
    input  mii_rx_t    mii_rx,
    input  logic       tx_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic       busy,
    output logic       overflow
);

    capture_state_t state;
    logic           word_done;
    frame_word_t    word;
    word_wr_t       wr;
    frame_len_t     frame_len;
    frame_addr_t    rd_addr;
    frame_word_t    rd_data;
    logic           dump_done;

    // anything but idle counts as busy
    assign busy = (state != cap_idle);

    // idle / rec / dump sequencing
    capture_fsm u_capture_fsm (
        .mainclk   (mainclk),
        .rst       (rst),
        .arm       (arm),
        .rx_dv     (mii_rx.dv),
        .frame_len (frame_len),
        .dump_done (dump_done),
        .state     (state)
    );

    // mii nibbles into 32-bit words
    rx_word_packer u_rx_word_packer (
        .mainclk   (mainclk),
        .rst       (rst),
        .state     (state),
        .mii_rx    (mii_rx),
        .word_done (word_done),
        .word      (word)
    );

    // write address and saturating length
    frame_addr_counter u_frame_addr_counter (
        .mainclk   (mainclk),
        .rst       (rst),
        .state     (state),
        .word_done (word_done),
        .word      (word),
        .wr        (wr),
        .frame_len (frame_len),
        .overflow  (overflow)
    );

    frame_ram u_frame_ram (
        .mainclk (mainclk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // stored words out as ascii hex
    hex_dump_tx u_hex_dump_tx (
        .mainclk   (mainclk),
        .rst       (rst),
        .state     (state),
        .frame_len (frame_len),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .tx_ready  (tx_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .dump_done (dump_done)
    );

endmodule

/* logic/hex_dump_tx.sv */
`include "eth_dump_defs.svh"

module hex_dump_tx
    import eth_dump_pkg::*;
(
    input  logic           mainclk,
    input  logic           rst,
    input  capture_state_t state,
    input  frame_len_t     frame_len,
    output frame_addr_t    rd_addr,
    input  frame_word_t    rd_data,
    input  logic           tx_ready,
    output logic [7:0]     tx_data,
    output logic           tx_valid,
    output logic           dump_done
);

    frame_len_t  word_cnt;
    logic [2:0]  nib_cnt;
    logic        rd_wait;
    logic        loaded;
    logic        more_words;
    logic        load_word;
    logic        send_char;
    frame_word_t nib_buf;

    // swap the two nibbles of every byte
    // so shifting out from bits 3:0 gives high digit first
    function automatic frame_word_t pair_flip(frame_word_t w);
        frame_word_t r;
        for (int b = 0; b < `ETH_WORD_W / 8; b++) begin
            r[b*8 +: 4]   = w[b*8+4 +: 4];
            r[b*8+4 +: 4] = w[b*8 +: 4];
        end
        return r;
    endfunction

    // nibble to lower-case ascii hex
    function automatic logic [7:0] hex_char(mii_nibble_t n);
        if (n < 4'd10) begin
            return 8'h30 + 8'(n);
        end
        return 8'h57 + 8'(n);
    endfunction

    assign rd_addr    = word_cnt[`ETH_ADDR_W-1:0];
    assign more_words = (state == cap_dump) && (word_cnt != frame_len);
    // rd_wait means the ram has had one edge with this address
    assign load_word  = more_words && !loaded && rd_wait;
    // one strobe per ready, never two cycles back to back
    assign send_char  = loaded && tx_ready && !tx_valid;

    always_ff @(posedge mainclk) begin
        if (rst || state != cap_dump) begin
            word_cnt  <= '0;
            nib_cnt   <= '0;
            rd_wait   <= 1'b0;
            loaded    <= 1'b0;
            tx_valid  <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            tx_valid  <= 1'b0;
            dump_done <= 1'b0;
            if (more_words && !loaded) begin
                rd_wait <= 1'b1;
            end
            if (load_word) begin
                loaded <= 1'b1;
            end
            if (send_char) begin
                tx_valid <= 1'b1;
                nib_cnt  <= nib_cnt + 3'd1;
                // last nibble of this word, move to the next address
                if (nib_cnt == 3'(`ETH_NIBBLES_PER_WORD - 1)) begin
                    loaded   <= 1'b0;
                    rd_wait  <= 1'b0;
                    word_cnt <= word_cnt + 1'b1;
                    if (frame_len_t'(word_cnt + 1'b1) == frame_len) begin
                        dump_done <= 1'b1;
                    end
                end
            end
        end
    end

    // character payload and nibble buffer
    always_ff @(posedge mainclk) begin
        if (load_word) begin
            nib_buf <= pair_flip(rd_data);
        end else if (send_char) begin
            nib_buf <= nib_buf >> `ETH_NIBBLE_W;
        end
        if (send_char) begin
            tx_data <= hex_char(nib_buf[`ETH_NIBBLE_W-1:0]);
        end
    end

endmodule

/* logic/frame_ram.sv */
`include "eth_dump_defs.svh"

module frame_ram (
    input  logic                      mainclk,
    input  eth_dump_pkg::word_wr_t    wr,
    input  eth_dump_pkg::frame_addr_t rd_addr,
    output eth_dump_pkg::frame_word_t rd_data
);

    // frame storage, one 32-bit word per 8 mii nibbles
    eth_dump_pkg::frame_word_t mem [`ETH_FRAME_DEPTH];

    // write port, fed by the address counter
    always_ff @(posedge mainclk) begin
        if (wr.ena) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, one cycle latency
    // read during write of same address returns old data
    always_ff @(posedge mainclk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* logic/frame_addr_counter.sv */
`include "eth_dump_defs.svh"

module frame_addr_counter
    import eth_dump_pkg::*;
(
    input  logic           mainclk,
    input  logic           rst,
    input  capture_state_t state,
    input  logic           word_done,
    input  frame_word_t    word,
    output word_wr_t       wr,
    output frame_len_t     frame_len,
    output logic           overflow
);

    capture_state_t prev_state;
    logic           rec_entry;
    logic           full;

    // first cycle of rec
    assign rec_entry = (state == cap_rec) && (prev_state != cap_rec);

    // stop writing instead of wrapping the address
    assign full = (frame_len == frame_len_t'(`ETH_FRAME_DEPTH));

    // write lands in the same cycle as word_done
    // word count doubles as the next free address
    always_comb begin
        wr.ena  = word_done && (state == cap_rec) && !full;
        wr.addr = frame_len[`ETH_ADDR_W-1:0];
        wr.data = word;
    end

    always_ff @(posedge mainclk) begin
        if (rst) begin
            prev_state <= cap_idle;
            frame_len  <= '0;
            overflow   <= 1'b0;
        end else begin
            prev_state <= state;
            if (rec_entry) begin
                // new frame, address back to zero
                frame_len <= '0;
                overflow  <= 1'b0;
            end else if (wr.ena) begin
                frame_len <= frame_len + 1'b1;
            end else if (word_done && full) begin
                // sticky until next frame
                overflow <= 1'b1;
            end
        end
    end

endmodule

/* logic/rx_word_packer.sv */
`include "eth_dump_defs.svh"

module rx_word_packer
    import eth_dump_pkg::*;
(
    input  logic           mainclk,
    input  logic           rst,
    input  capture_state_t state,
    input  mii_rx_t        mii_rx,
    output logic           word_done,
    output frame_word_t    word
);

    // nibble shifter, new nibble enters at the top
    frame_word_t shift_q;
    frame_word_t shift_next;
    logic [2:0]  nib_cnt;
    logic        take;
    logic        last_nib;

    // only valid nibbles during rec are packed
    assign take       = (state == cap_rec) && mii_rx.dv;
    assign last_nib   = (nib_cnt == 3'(`ETH_NIBBLES_PER_WORD - 1));
    assign shift_next = {mii_rx.data, shift_q[`ETH_WORD_W-1:`ETH_NIBBLE_W]};

    // first nibble on the wire ends up in bits 3:0
    // so each byte already reads second*16 + first

    always_ff @(posedge mainclk) begin
        if (rst || state != cap_rec) begin
            // leftover nibbles of a partial word are dropped here
            nib_cnt   <= '0;
            shift_q   <= '0;
            word_done <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (take) begin
                shift_q <= shift_next;
                nib_cnt <= nib_cnt + 3'd1;
                // eighth nibble completes the word
                if (last_nib) begin
                    word_done <= 1'b1;
                end
            end
        end
    end

    // word payload, held until the next complete word
    always_ff @(posedge mainclk) begin
        if (take && last_nib) begin
            word <= shift_next;
        end
    end

endmodule

/* logic/capture_fsm.sv */
module capture_fsm
    import eth_dump_pkg::*;
(
    input  logic           mainclk,
    input  logic           rst,
    input  logic           arm,
    input  logic           rx_dv,
    input  frame_len_t     frame_len,
    input  logic           dump_done,
    output capture_state_t state
);

    // dv one cycle late
    // by the time it reads low the last word write has landed in frame_len
    logic rx_dv_q;

    always_ff @(posedge mainclk) begin
        if (rst) begin
            state   <= cap_idle;
            rx_dv_q <= 1'b0;
        end else begin
            rx_dv_q <= rx_dv;
            case (state)
                cap_idle: begin
                    // start nibble itself is not captured
                    if (arm && rx_dv) begin
                        state <= cap_rec;
                    end
                end
                cap_rec: begin
                    // frame over
                    if (!rx_dv_q) begin
                        // nothing stored, skip the dump
                        if (frame_len == '0) begin
                            state <= cap_idle;
                        end else begin
                            state <= cap_dump;
                        end
                    end
                end
                cap_dump: begin
                    if (dump_done) begin
                        state <= cap_idle;
                    end
                end
                default: begin
                    state <= cap_idle;
                end
            endcase
        end
    end

endmodule

/* logic/eth_dump_pkg.sv */
`include "eth_dump_defs.svh"

package eth_dump_pkg;

    // capture sequence, no error or playback states
    typedef enum logic [1:0] {
        cap_idle = 2'd0,
        cap_rec  = 2'd1,
        cap_dump = 2'd2
    } capture_state_t;

    typedef logic [`ETH_NIBBLE_W-1:0] mii_nibble_t;
    typedef logic [`ETH_WORD_W-1:0]   frame_word_t;
    typedef logic [`ETH_ADDR_W-1:0]   frame_addr_t;

    // one extra bit so a full ram (512) is representable
    typedef logic [`ETH_ADDR_W:0]     frame_len_t;

    // mii receive pins, already in the mainclk domain
    typedef struct packed {
        logic        dv;
        mii_nibble_t data;
    } mii_rx_t;

    // ram write port bundle
    typedef struct packed {
        logic        ena;
        frame_addr_t addr;
        frame_word_t data;
    } word_wr_t;

endpackage

/* include/eth_dump_defs.svh */
`ifndef ETH_DUMP_DEFS_SVH
`define ETH_DUMP_DEFS_SVH

// mii receive data, one nibble per mainclk
`define ETH_NIBBLE_W 4

// one stored frame word
`define ETH_WORD_W 32

// nibbles packed per stored word
`define ETH_NIBBLES_PER_WORD 8

// frame ram geometry, 512 words of 32 bits
`define ETH_ADDR_W 9
`define ETH_FRAME_DEPTH 512

`endif
